/* run_sim.sh */
#!/bin/sh
# build and run the interrupt entry testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module ie_tb -f sources.f -o ie_sim
status=0
./obj_dir/ie_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log
echo "simulator exit status $status"
grep -qx "SIMULATION PASSED" sim.log

/* sources.f */
verilog/ie_pkg.sv
verilog/ie_vector_calc.sv
verilog/ie_context_capture.sv
verilog/ie_sequencer.sv
verilog/ie_packet_gen.sv
verilog/fetch2_packet_select.sv
verilog/ie_top.sv
verif/ie_properties.sv
verif/ie_tb.sv

/* verif/ie_properties.sv */
`timescale 1ns/1ps

module ie_properties (
    input logic               clk,
    input logic               arst_n,
    input logic               enable,
    input logic               rrag_stall,
    input logic               flush_pipe,
    input logic               is_pop_eflags,
    input logic               invalidate_fetch,
    input ie_pkg::seq_state_e state
);

    int unsigned fail_count = 0;    // testbench reads this at the end

    // a flush that may advance is gone after one edge
    flush_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        flush_pipe && enable && !rrag_stall |=> !flush_pipe)
        else begin
            fail_count++;
            $error("flush_pipe still high after an advancing edge");
        end

    pop_not_flush: assert property (@(posedge clk) disable iff (!arst_n)
        !(is_pop_eflags && flush_pipe))
        else begin
            fail_count++;
            $error("is_pop_eflags and flush_pipe high together");
        end

    stall_holds_state: assert property (@(posedge clk) disable iff (!arst_n)
        rrag_stall |=> $stable(state))
        else begin
            fail_count++;
            $error("state moved under rrag_stall");
        end

    invalidate_in_wait: assert property (@(posedge clk) disable iff (!arst_n)
        invalidate_fetch |-> state == ie_pkg::WAIT_ENTRY)
        else begin
            fail_count++;
            $error("invalidate_fetch raised outside the wait state");
        end

endmodule

/* verif/ie_tb.sv */
`timescale 1ns/1ps

module ie_tb;

    localparam int NUM_RUNS       = 8;
    localparam int RUN_CYCLES     = 45;    // entry, handler and return with no stall
    localparam int TIMEOUT_CYCLES = NUM_RUNS * RUN_CYCLES * 3 + 50;

    logic             clk, arst_n, enable, ie_req, is_iretd, rrag_stall, final_switch_wb;
    logic             fetch_from_idt, flush_pipe, ld_eip, is_pop_eflags;
    logic             servicing_ie, switching, invalidate_fetch;
    ie_pkg::ie_type_t ie_type;
    ie_pkg::addr_t    idt_base;
    ie_pkg::wb_ctx_s  wb_ctx;
    ie_pkg::packet_t  ibuff_packet, fetch_packet;

    logic [15:0]      lfsr_q = 16'd26157;
    int               cycle_count = 0;

    // reference model
    ie_pkg::seq_state_e m_state;
    logic               m_fsq, m_returning, m_from_idt, m_pkt_valid;
    ie_pkg::packet_t    m_pkt;
    ie_pkg::wb_ctx_s    cap_ctx;
    ie_pkg::ie_type_t   cap_type;
    ie_pkg::addr_t      cap_base;

    ie_top i_dut (.*);

    bind ie_sequencer ie_properties i_properties (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // taps of x^16 + x^14 + x^13 + x^11 + 1, stepped once per bit
    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] r;
        logic         fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            r      = {r[126:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] le32(input logic [31:0] v);
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            r[8*i +: 8] = v[8*(3-i) +: 8];
        end
        return r;
    endfunction

    function automatic logic injects(input ie_pkg::seq_state_e s);
        return (s >= ie_pkg::PUSH_CS && s <= ie_pkg::JUMP) ||
               s inside {ie_pkg::RET_FAR, ie_pkg::POP_FLAGS};
    endfunction

    function automatic ie_pkg::packet_t expected_packet(input ie_pkg::seq_state_e step,
                                                        input ie_pkg::wb_ctx_s ctx,
                                                        input ie_pkg::ie_type_t typ,
                                                        input ie_pkg::addr_t base);
        logic [7:0]  vec;
        logic [31:0] gate;
        vec  = typ[0] ? 8'd13 : (typ[1] ? 8'd14 : (typ[2] ? 8'd15 : 8'd0));
        gate = base + {21'd0, vec, 3'd0};    // 8 byte gates
        case (step)
            ie_pkg::PUSH_CS:       return {8'h68, le32({16'h0, ctx.cs}), 88'h0};
            ie_pkg::PUSH_EIP:      return {8'h68, le32(ctx.eip), 88'h0};
            ie_pkg::PUSH_EFLAGS:   return {8'h68, le32({14'h0, ctx.eflags}), 88'h0};
            ie_pkg::LOAD_OFFSET:   return {16'h8b0d, le32(gate), 80'h0};
            ie_pkg::LOAD_SELECTOR: return {16'h8b15, le32(gate + 32'd4), 80'h0};
            ie_pkg::SWAP:          return {24'h6687d1, 104'h0};
            ie_pkg::SHIFT:         return {24'hc1f904, 104'h0};
            ie_pkg::LOAD_CS:       return {24'h668ec9, 104'h0};
            ie_pkg::JUMP:          return {16'hffe2, 112'h0};
            ie_pkg::RET_FAR:       return {8'hcb, 120'h0};
            ie_pkg::POP_FLAGS:     return {8'h59, 120'h0};
            default:               return '0;
        endcase
    endfunction

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        if (actual !== expected) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one clock with fresh background traffic
    task automatic tick();
        @(posedge clk);
        rrag_stall   <= (rand_bits(2) == 128'd0);    // roughly one cycle in four
        enable       <= (rand_bits(3) != 128'd0);
        ibuff_packet <= rand_bits(128);
    endtask

    // final switch retires some cycles into the wait and is held until the wait is left
    task automatic finish_switch();
        do tick(); while (!invalidate_fetch);
        repeat (int'(rand_bits(3))) tick();
        final_switch_wb <= 1'b1;
        do tick(); while (switching);
        final_switch_wb <= 1'b0;
    endtask

    task automatic run_sequence(input int run);
        ie_pkg::ie_type_t t;
        t = (run < 3) ? ie_pkg::ie_type_t'(3'b001 << run) : 3'(rand_bits(3));
        if (t == '0) begin
            t = 3'b100;
        end
        ie_type  <= t;
        idt_base <= 32'(rand_bits(32));
        wb_ctx   <= 66'(rand_bits(66));
        ie_req   <= 1'b1;
        do tick(); while (!flush_pipe);
        ie_req   <= 1'b0;
        // new writeback, type and base must not leak into the injected packets
        wb_ctx   <= 66'(rand_bits(66));
        ie_type  <= 3'(rand_bits(3));
        idt_base <= 32'(rand_bits(32));
        finish_switch();
        repeat (2 + int'(rand_bits(3))) tick();    // handler runs from ibuff
        is_iretd <= 1'b1;
        do tick(); while (!flush_pipe);
        is_iretd <= 1'b0;
        finish_switch();
        tick();
    endtask

    initial begin
        arst_n          <= 1'b0;
        enable          <= 1'b1;
        ie_req          <= 1'b0;
        ie_type         <= '0;
        idt_base        <= '0;
        wb_ctx          <= '0;
        is_iretd        <= 1'b0;
        rrag_stall      <= 1'b0;
        final_switch_wb <= 1'b0;
        ibuff_packet    <= '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        for (int run = 0; run < NUM_RUNS; run++) begin
            run_sequence(run);
        end
        repeat (4) tick();
        if (i_dut.i_sequencer.i_properties.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("concurrent assertions on the sequencer failed");
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // model follows the sequencer and fetch timing rules
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_state     = ie_pkg::IDLE;
            m_fsq       = 1'b0;
            m_returning = 1'b0;
            m_from_idt  = 1'b0;
            m_pkt_valid = 1'b0;
        end else if (enable) begin
            if (m_state == ie_pkg::IDLE) begin
                cap_ctx  = wb_ctx;
                cap_type = ie_type;
                cap_base = idt_base;
            end
            if (!rrag_stall) begin
                m_from_idt  = injects(m_state);
                m_pkt       = m_from_idt ? expected_packet(m_state, cap_ctx, cap_type, cap_base)
                                         : ibuff_packet;
                m_pkt_valid = 1'b1;
                case (m_state)
                    ie_pkg::IDLE: begin
                        if (ie_req) begin
                            m_state = ie_pkg::ENTRY_FLUSH;
                        end
                    end
                    ie_pkg::WAIT_ENTRY: begin
                        if (m_fsq) begin
                            m_state     = m_returning ? ie_pkg::IDLE : ie_pkg::SERVICE;
                            m_returning = 1'b0;
                        end
                    end
                    ie_pkg::SERVICE: begin
                        if (is_iretd) begin
                            m_state     = ie_pkg::RET_FLUSH;
                            m_returning = 1'b1;
                        end
                    end
                    ie_pkg::POP_FLAGS: m_state = ie_pkg::WAIT_ENTRY;
                    default: m_state = ie_pkg::seq_state_e'(m_state + 1);    // one step per cycle
                endcase
            end
            m_fsq = final_switch_wb;
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (arst_n) begin
            check("fetch_from_idt", 128'(m_from_idt), 128'(fetch_from_idt));
            if (m_pkt_valid) begin
                check("fetch_packet", m_pkt, fetch_packet);
            end
            check("flush_pipe", 128'(m_state inside {ie_pkg::ENTRY_FLUSH, ie_pkg::RET_FLUSH}),
                  128'(flush_pipe));
            check("ld_eip", 128'(m_state inside {ie_pkg::IDLE, ie_pkg::JUMP, ie_pkg::RET_FAR}),
                  128'(ld_eip));
            check("is_pop_eflags", 128'(m_state == ie_pkg::POP_FLAGS), 128'(is_pop_eflags));
            check("servicing_ie", 128'(!(m_state inside {ie_pkg::IDLE, ie_pkg::ENTRY_FLUSH})),
                  128'(servicing_ie));
            check("switching", 128'(!(m_state inside {ie_pkg::IDLE, ie_pkg::SERVICE})),
                  128'(switching));
            check("invalidate_fetch", 128'(m_state == ie_pkg::WAIT_ENTRY && !m_fsq),
                  128'(invalidate_fetch));
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout, the sequences did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $fatal(1, "run stopped on timeout");
        end
    end

endmodule

/* verilog/fetch2_packet_select.sv */
`timescale 1ns/1ps

module fetch2_packet_select (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            enable,
    input  logic            rrag_stall,
    input  logic            inject,
    input  ie_pkg::packet_t idt_packet,
    input  ie_pkg::packet_t ibuff_packet,
    output ie_pkg::packet_t fetch_packet,
    output logic            fetch_from_idt
);

    logic load;

    assign load = enable && !rrag_stall;   // hold under back-pressure

    // source flag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_from_idt <= 1'b0;
        end else if (load) begin
            fetch_from_idt <= inject;
        end
    end

    // packet payload
    always_ff @(posedge clk) begin
        if (load) begin
            fetch_packet <= inject ? idt_packet : ibuff_packet;
        end
    end

endmodule

/* verilog/ie_context_capture.sv */
`timescale 1ns/1ps

module ie_context_capture (
    input  logic               clk,
    input  logic               ld_info,
    input  ie_pkg::wb_ctx_s    wb_ctx,
    input  ie_pkg::idt_entry_s entry,
    output ie_pkg::wb_ctx_s    ctx_q,
    output ie_pkg::idt_entry_s entry_q
);

    // writeback context of the instruction that faults
    // reloaded every idle cycle, frozen once the sequence starts
    always_ff @(posedge clk) begin
        if (ld_info) begin
            ctx_q <= wb_ctx;
        end
    end

    // gate addresses for the two MOV packets
    always_ff @(posedge clk) begin
        if (ld_info) begin
            entry_q <= entry;
        end
    end

endmodule

/* verilog/ie_packet_gen.sv */
`timescale 1ns/1ps

module ie_packet_gen (
    input  ie_pkg::seq_state_e state,
    input  ie_pkg::wb_ctx_s    ctx_q,
    input  ie_pkg::idt_entry_s entry_q,
    output ie_pkg::packet_t    idt_packet,
    output logic               inject
);

    // immediates go out little endian
    function automatic logic [31:0] swap32(input logic [31:0] w);
        swap32 = {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic ie_pkg::packet_t push_packet(input logic [31:0] imm);
        push_packet = '0;
        push_packet[ie_pkg::PACKET_W-1 -: 40] = {ie_pkg::OP_PUSH_IMM, swap32(imm)};
    endfunction

    function automatic ie_pkg::packet_t mov_packet(input logic [15:0] op, input ie_pkg::addr_t a);
        mov_packet = '0;
        mov_packet[ie_pkg::PACKET_W-1 -: 48] = {op, swap32(a)};
    endfunction

    always_comb begin
        idt_packet = '0;
        inject     = 1'b1;
        case (state)
            ie_pkg::PUSH_CS:       idt_packet = push_packet(32'(ctx_q.cs));
            ie_pkg::PUSH_EIP:      idt_packet = push_packet(ctx_q.eip);
            ie_pkg::PUSH_EFLAGS:   idt_packet = push_packet(32'(ctx_q.eflags));
            ie_pkg::LOAD_OFFSET: begin
                idt_packet = mov_packet(ie_pkg::OP_MOV_ECX_MEM, entry_q.entry_addr);
            end
            ie_pkg::LOAD_SELECTOR: begin
                idt_packet = mov_packet(ie_pkg::OP_MOV_EDX_MEM, entry_q.entry_addr4);
            end
            ie_pkg::SWAP:    idt_packet[ie_pkg::PACKET_W-1 -: 24] = ie_pkg::OP_XCHG_CX_DX;
            ie_pkg::SHIFT:   idt_packet[ie_pkg::PACKET_W-1 -: 24] = ie_pkg::OP_SAR_ECX_4;
            ie_pkg::LOAD_CS: idt_packet[ie_pkg::PACKET_W-1 -: 24] = ie_pkg::OP_MOV_CS_CX;
            ie_pkg::JUMP:    idt_packet[ie_pkg::PACKET_W-1 -: 16] = ie_pkg::OP_JMP_EDX;
            ie_pkg::RET_FAR: idt_packet[ie_pkg::PACKET_W-1 -: 8]  = ie_pkg::OP_RET_FAR;
            ie_pkg::POP_FLAGS: begin
                idt_packet[ie_pkg::PACKET_W-1 -: 8] = ie_pkg::OP_POP_EFLAGS;
            end
            default: inject = 1'b0;    // ibuff owns fetch
        endcase
    end

endmodule

/* verilog/ie_pkg.sv */
package ie_pkg;

    localparam int ADDR_W    = 32;
    localparam int EIP_W     = 32;
    localparam int EFLAGS_W  = 18;
    localparam int CS_W      = 16;
    localparam int TYPE_W    = 3;
    localparam int VECTOR_W  = 8;
    localparam int PACKET_W  = 128;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [EIP_W-1:0]    eip_t;
    typedef logic [EFLAGS_W-1:0] eflags_t;
    typedef logic [CS_W-1:0]     cs_t;
    typedef logic [TYPE_W-1:0]   ie_type_t;   // [0] protection, [1] page fault, [2] interrupt
    typedef logic [VECTOR_W-1:0] vector_t;
    typedef logic [PACKET_W-1:0] packet_t;    // opcode left aligned, zero filled

    localparam vector_t VEC_PROTECTION = 8'd13;
    localparam vector_t VEC_PAGE_FAULT = 8'd14;
    localparam vector_t VEC_INTERRUPT  = 8'd15;

    localparam int IDT_ENTRY_BYTES    = 8;   // one gate descriptor
    localparam int SECOND_WORD_OFFSET = 4;

    // injected instruction encodings
    localparam logic [7:0]  OP_PUSH_IMM    = 8'h68;
    localparam logic [15:0] OP_MOV_ECX_MEM = 16'h8b0d;
    localparam logic [15:0] OP_MOV_EDX_MEM = 16'h8b15;
    localparam logic [23:0] OP_XCHG_CX_DX  = 24'h6687d1;
    localparam logic [23:0] OP_SAR_ECX_4   = 24'hc1f904;
    localparam logic [23:0] OP_MOV_CS_CX   = 24'h668ec9;
    localparam logic [15:0] OP_JMP_EDX     = 16'hffe2;
    localparam logic [7:0]  OP_RET_FAR     = 8'hcb;
    localparam logic [7:0]  OP_POP_EFLAGS  = 8'h59;    // pops into ecx, consumer loads eflags

    typedef enum logic [3:0] {
        IDLE,
        ENTRY_FLUSH,
        PUSH_CS,
        PUSH_EIP,
        PUSH_EFLAGS,
        LOAD_OFFSET,
        LOAD_SELECTOR,
        SWAP,
        SHIFT,
        LOAD_CS,
        JUMP,
        WAIT_ENTRY,     // final switch wait, shared by entry and return
        SERVICE,
        RET_FLUSH,
        RET_FAR,
        POP_FLAGS
    } seq_state_e;

    typedef struct packed {
        eip_t    eip;
        eflags_t eflags;
        cs_t     cs;
    } wb_ctx_s;

    typedef struct packed {
        addr_t entry_addr;
        addr_t entry_addr4;
    } idt_entry_s;

endpackage

/* verilog/ie_sequencer.sv */
`timescale 1ns/1ps

module ie_sequencer (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               enable,
    input  logic               ie_req,
    input  logic               is_iretd,
    input  logic               rrag_stall,
    input  logic               final_switch_wb,
    output ie_pkg::seq_state_e state,
    output logic               ld_info,
    output logic               flush_pipe,
    output logic               ld_eip,
    output logic               is_pop_eflags,
    output logic               servicing_ie,
    output logic               switching,
    output logic               invalidate_fetch
);

    ie_pkg::seq_state_e next_state;
    logic               final_switch_q;   // registered final_switch_wb
    logic               returning;        // set while on the iretd path
    logic               advance;

    assign advance = enable && !rrag_stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state          <= ie_pkg::IDLE;
            returning      <= 1'b0;
            final_switch_q <= 1'b0;
        end else begin
            if (enable) begin
                final_switch_q <= final_switch_wb;
            end
            if (advance) begin
                state <= next_state;
                if (next_state == ie_pkg::RET_FLUSH) begin
                    returning <= 1'b1;
                end else if (next_state == ie_pkg::IDLE) begin
                    returning <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ie_pkg::IDLE: begin
                if (ie_req) begin
                    next_state = ie_pkg::ENTRY_FLUSH;
                end
            end
            ie_pkg::ENTRY_FLUSH:   next_state = ie_pkg::PUSH_CS;
            ie_pkg::PUSH_CS:       next_state = ie_pkg::PUSH_EIP;
            ie_pkg::PUSH_EIP:      next_state = ie_pkg::PUSH_EFLAGS;
            ie_pkg::PUSH_EFLAGS:   next_state = ie_pkg::LOAD_OFFSET;
            ie_pkg::LOAD_OFFSET:   next_state = ie_pkg::LOAD_SELECTOR;
            ie_pkg::LOAD_SELECTOR: next_state = ie_pkg::SWAP;
            ie_pkg::SWAP:          next_state = ie_pkg::SHIFT;
            ie_pkg::SHIFT:         next_state = ie_pkg::LOAD_CS;
            ie_pkg::LOAD_CS:       next_state = ie_pkg::JUMP;
            ie_pkg::JUMP:          next_state = ie_pkg::WAIT_ENTRY;
            ie_pkg::WAIT_ENTRY: begin
                // leave once the switching instruction retires
                if (final_switch_q) begin
                    next_state = returning ? ie_pkg::IDLE : ie_pkg::SERVICE;
                end
            end
            ie_pkg::SERVICE: begin
                if (is_iretd) begin
                    next_state = ie_pkg::RET_FLUSH;
                end
            end
            ie_pkg::RET_FLUSH:     next_state = ie_pkg::RET_FAR;
            ie_pkg::RET_FAR:       next_state = ie_pkg::POP_FLAGS;
            ie_pkg::POP_FLAGS:     next_state = ie_pkg::WAIT_ENTRY;
        endcase
    end

    // control decode, all from the current state
    assign ld_info       = (state == ie_pkg::IDLE);
    assign flush_pipe    = (state == ie_pkg::ENTRY_FLUSH) || (state == ie_pkg::RET_FLUSH);
    assign is_pop_eflags = (state == ie_pkg::POP_FLAGS);

    // eip reload in idle, at the jump into the handler and on ret far
    assign ld_eip = (state == ie_pkg::IDLE) || (state == ie_pkg::JUMP) ||
                    (state == ie_pkg::RET_FAR);

    assign servicing_ie = !((state == ie_pkg::IDLE) || (state == ie_pkg::ENTRY_FLUSH));
    assign switching    = !((state == ie_pkg::IDLE) || (state == ie_pkg::SERVICE));

    // fetch is junk until the final switch instruction reaches writeback
    assign invalidate_fetch = (state == ie_pkg::WAIT_ENTRY) && !final_switch_q;

endmodule

/* verilog/ie_top.sv */
`timescale 1ns/1ps

module ie_top (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             enable,
    input  logic             ie_req,
    input  ie_pkg::ie_type_t ie_type,
    input  ie_pkg::addr_t    idt_base,
    input  ie_pkg::wb_ctx_s  wb_ctx,
    input  logic             is_iretd,
    input  logic             rrag_stall,
    input  logic             final_switch_wb,
    input  ie_pkg::packet_t  ibuff_packet,
    output ie_pkg::packet_t  fetch_packet,
    output logic             fetch_from_idt,
    output logic             flush_pipe,
    output logic             ld_eip,
    output logic             is_pop_eflags,
    output logic             servicing_ie,
    output logic             switching,
    output logic             invalidate_fetch
);

    ie_pkg::idt_entry_s entry;
    ie_pkg::idt_entry_s entry_q;
    ie_pkg::wb_ctx_s    ctx_q;
    ie_pkg::seq_state_e state;
    ie_pkg::packet_t    idt_packet;
    logic               ld_info;
    logic               inject;

    ie_vector_calc i_vector_calc (
        .ie_type (ie_type),
        .idt_base(idt_base),
        .entry   (entry)
    );

    // info registers freeze with the rest of the block
    ie_context_capture i_context_capture (
        .clk    (clk),
        .ld_info(ld_info && enable),
        .wb_ctx (wb_ctx),
        .entry  (entry),
        .ctx_q  (ctx_q),
        .entry_q(entry_q)
    );

    ie_sequencer i_sequencer (
        .clk             (clk),
        .arst_n          (arst_n),
        .enable          (enable),
        .ie_req          (ie_req),
        .is_iretd        (is_iretd),
        .rrag_stall      (rrag_stall),
        .final_switch_wb (final_switch_wb),
        .state           (state),
        .ld_info         (ld_info),
        .flush_pipe      (flush_pipe),
        .ld_eip          (ld_eip),
        .is_pop_eflags   (is_pop_eflags),
        .servicing_ie    (servicing_ie),
        .switching       (switching),
        .invalidate_fetch(invalidate_fetch)
    );

    ie_packet_gen i_packet_gen (
        .state     (state),
        .ctx_q     (ctx_q),
        .entry_q   (entry_q),
        .idt_packet(idt_packet),
        .inject    (inject)
    );

    fetch2_packet_select i_fetch2_select (
        .clk           (clk),
        .arst_n        (arst_n),
        .enable        (enable),
        .rrag_stall    (rrag_stall),
        .inject        (inject),
        .idt_packet    (idt_packet),
        .ibuff_packet  (ibuff_packet),
        .fetch_packet  (fetch_packet),
        .fetch_from_idt(fetch_from_idt)
    );

endmodule

/* verilog/ie_vector_calc.sv */
`timescale 1ns/1ps

module ie_vector_calc (
    input  ie_pkg::ie_type_t   ie_type,
    input  ie_pkg::addr_t      idt_base,
    output ie_pkg::idt_entry_s entry
);

    ie_pkg::vector_t vector;
    ie_pkg::addr_t   gate_offset;
    ie_pkg::addr_t   entry_addr;

    // lowest set type bit wins
    always_comb begin
        if (ie_type[0]) begin
            vector = ie_pkg::VEC_PROTECTION;
        end else if (ie_type[1]) begin
            vector = ie_pkg::VEC_PAGE_FAULT;
        end else if (ie_type[2]) begin
            vector = ie_pkg::VEC_INTERRUPT;
        end else begin
            vector = '0;    // no fault, address unused
        end
    end

    // each gate is eight bytes wide
    assign gate_offset = ie_pkg::addr_t'(vector) * ie_pkg::addr_t'(ie_pkg::IDT_ENTRY_BYTES);
    assign entry_addr  = idt_base + gate_offset;

    assign entry.entry_addr  = entry_addr;
    assign entry.entry_addr4 = entry_addr + ie_pkg::addr_t'(ie_pkg::SECOND_WORD_OFFSET);   // selector word

endmodule
